/* chdr_pkg.sv */
/*
 * CHDR packet definitions: bus word, header record layout and
 * the field widths shared by the deframer, framer and checker
 */
package chdr_pkg;

  localparam int SEQ_W          = 12;
  localparam int SID_W          = 16;
  localparam int BYTES_PER_WORD = 8;

  typedef logic [63:0] chdr_word_t;

  // Field order matches the header word, MSB first
  typedef struct packed {
    logic [3:0]       flags;
    logic [SEQ_W-1:0] seqnum;
    logic [15:0]      size;
    logic [SID_W-1:0] src_sid;
    logic [SID_W-1:0] dst_sid;
  } hdr_info_t;

endpackage

/* split_cfg_pkg.sv */
/*
 * Split stream configuration: settings bus register map and credit width
 */
package split_cfg_pkg;

  localparam int SET_ADDR_W = 8;
  localparam int SET_DATA_W = 32;

  // Branch k: src SID at base + 2k, dst SID at base + 2k + 1
  localparam logic [SET_ADDR_W-1:0] REG_SID_BASE  = 8'h10;
  // One bit per branch
  localparam logic [SET_ADDR_W-1:0] REG_CLEAR_SEQ = 8'h08;

  localparam int CREDIT_W = 8;

endpackage

/* stream_fifo.sv */
/*
 * Synchronous FIFO with valid/ready on both sides, item type set by parameter
 */
module stream_fifo #(
  parameter type item_t     = logic [63:0],
  parameter int  DEPTH_LOG2 = 4
) (
  input  logic  i_ce_clk,
  input  logic  i_rst,
  input  item_t i_data,
  input  logic  i_valid,
  output logic  o_ready,
  output item_t o_data,
  output logic  o_valid,
  input  logic  i_ready
);

  localparam int PTR_W = DEPTH_LOG2 + 1;
  localparam int DEPTH = 1 << DEPTH_LOG2;

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] fill;

  // Extra pointer bit tells full from empty
  assign fill    = wr_ptr - rd_ptr;
  assign o_ready = ~fill[DEPTH_LOG2];
  assign o_valid = (fill != '0);
  assign o_data  = mem[rd_ptr[DEPTH_LOG2-1:0]];

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_valid && o_ready) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (o_valid && i_ready) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_valid && o_ready) begin
      mem[wr_ptr[DEPTH_LOG2-1:0]] <= i_data;
    end
  end

  // A write refused while full stays on offer until there is room
  assert property (@(posedge i_ce_clk) disable iff (i_rst)
    (i_valid && !o_ready) |=> (i_valid && $stable(i_data)))
    else $error("write offered to a full FIFO was withdrawn");

endmodule

/* chdr_deframer.sv */
/*
 * CHDR deframer: drops the header word and tags each payload word
 * with the header record of its packet, through one register stage
 */
module chdr_deframer (
  input  logic                  i_ce_clk,
  input  logic                  i_rst,
  input  chdr_pkg::chdr_word_t  i_tdata,
  input  logic                  i_tlast,
  input  logic                  i_tvalid,
  output logic                  o_tready,
  output chdr_pkg::chdr_word_t  o_tdata,
  output chdr_pkg::hdr_info_t   o_hdr,
  output logic                  o_tlast,
  output logic                  o_tvalid,
  input  logic                  i_tready
);

  typedef enum logic {ST_HDR, ST_PAY} state_t;

  state_t              state;
  logic                run_q;
  logic                in_fire;
  chdr_pkg::hdr_info_t hdr_q;

  // Header beat never touches the output register
  assign o_tready = run_q & ((state == ST_HDR) | ~o_tvalid | i_tready);
  assign in_fire  = i_tvalid & o_tready;

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      state    <= ST_HDR;
      run_q    <= 1'b0;
      o_tvalid <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (o_tvalid && i_tready) begin
        o_tvalid <= 1'b0;
      end
      if (in_fire) begin
        if (state == ST_HDR) begin
          state <= ST_PAY;
        end else begin
          o_tvalid <= 1'b1;
          if (i_tlast) begin
            state <= ST_HDR;
          end
        end
      end
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (in_fire) begin
      if (state == ST_HDR) begin
        hdr_q <= chdr_pkg::hdr_info_t'(i_tdata);
      end else begin
        o_tdata <= i_tdata;
        o_hdr   <= hdr_q;
        o_tlast <= i_tlast;
      end
    end
  end

  // Header alone is not a packet
  assert property (@(posedge i_ce_clk) disable iff (i_rst)
    (in_fire && state == ST_HDR) |-> !i_tlast)
    else $error("packet without payload");

endmodule

/* stream_splitter.sv */
/*
 * Stream splitter: broadcasts each word to every branch and releases
 * the input once all branches have taken it
 */
module stream_splitter #(
  parameter int NUM_OUTPUTS = 2
) (
  input  logic                                               i_ce_clk,
  input  logic                                               i_rst,
  input  chdr_pkg::chdr_word_t                               i_tdata,
  input  chdr_pkg::hdr_info_t                                i_hdr,
  input  logic                                               i_tlast,
  input  logic                                               i_tvalid,
  output logic                                               o_tready,
  output logic [NUM_OUTPUTS*$bits(chdr_pkg::chdr_word_t)-1:0] o_tdata,
  output logic [NUM_OUTPUTS*$bits(chdr_pkg::hdr_info_t)-1:0]  o_hdr,
  output logic [NUM_OUTPUTS-1:0]                             o_tlast,
  output logic [NUM_OUTPUTS-1:0]                             o_tvalid,
  input  logic [NUM_OUTPUTS-1:0]                             i_tready
);

  logic [NUM_OUTPUTS-1:0] taken;
  logic [NUM_OUTPUTS-1:0] done;

  assign o_tdata = {NUM_OUTPUTS{i_tdata}};
  assign o_hdr   = {NUM_OUTPUTS{i_hdr}};
  assign o_tlast = {NUM_OUTPUTS{i_tlast}};

  // Branches that already took the word see valid low
  assign o_tvalid = {NUM_OUTPUTS{i_tvalid}} & ~taken;
  assign done     = taken | i_tready;
  assign o_tready = &done;

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      taken <= '0;
    end else if (i_tvalid && o_tready) begin
      taken <= '0;
    end else begin
      taken <= taken | (o_tvalid & i_tready);
    end
  end

endmodule

/* chdr_framer.sv */
/*
 * CHDR framer: buffers a whole packet, then sends a fresh header and
 * the payload, one word per cycle while credit lasts
 */
module chdr_framer #(
  parameter int MTU_LOG2 = 6
) (
  input  logic                         i_ce_clk,
  input  logic                         i_rst,
  input  chdr_pkg::chdr_word_t         i_tdata,
  input  chdr_pkg::hdr_info_t          i_hdr,
  input  logic                         i_tlast,
  input  logic                         i_tvalid,
  output logic                         o_tready,
  output chdr_pkg::chdr_word_t         o_tdata,
  output logic                         o_tlast,
  output logic                         o_tvalid,
  input  logic                         i_credit_ok,
  input  logic [chdr_pkg::SID_W-1:0]   i_src_sid,
  input  logic [chdr_pkg::SID_W-1:0]   i_dst_sid,
  input  logic                         i_seq_clear
);

  localparam int CNT_W = MTU_LOG2 + 1;

  logic                       pay_in_rdy;
  logic                       hdr_in_rdy;
  logic                       in_fire;
  logic [CNT_W-1:0]           in_cnt;
  chdr_pkg::hdr_info_t        hdr_in;
  chdr_pkg::chdr_word_t       pay_data;
  logic                       pay_valid;
  chdr_pkg::hdr_info_t        hdr_q;
  logic                       hdr_valid;
  chdr_pkg::hdr_info_t        hdr_out;
  logic                       in_pay;
  logic [CNT_W-1:0]           left;
  logic [chdr_pkg::SEQ_W-1:0] seq_q;
  logic                       hdr_fire;
  logic                       pay_fire;

  ////////////////////
  // Input side

  assign o_tready = pay_in_rdy & hdr_in_rdy;
  assign in_fire  = i_tvalid & o_tready;

  // Size covers the payload so far, this word and the header
  always_comb begin
    hdr_in      = i_hdr;
    hdr_in.size = (16'(in_cnt) + 16'd2) * 16'(chdr_pkg::BYTES_PER_WORD);
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      in_cnt <= '0;
    end else if (in_fire) begin
      in_cnt <= i_tlast ? '0 : in_cnt + 1'b1;
    end
  end

  stream_fifo #(
    .item_t     (chdr_pkg::chdr_word_t),
    .DEPTH_LOG2 (MTU_LOG2)
  ) u_pay_fifo (
    .i_ce_clk (i_ce_clk),
    .i_rst    (i_rst),
    .i_data   (i_tdata),
    .i_valid  (i_tvalid & hdr_in_rdy),
    .o_ready  (pay_in_rdy),
    .o_data   (pay_data),
    .o_valid  (pay_valid),
    .i_ready  (pay_fire)
  );

  // Record queued only once the packet is complete
  stream_fifo #(
    .item_t     (chdr_pkg::hdr_info_t),
    .DEPTH_LOG2 (2)
  ) u_hdr_fifo (
    .i_ce_clk (i_ce_clk),
    .i_rst    (i_rst),
    .i_data   (hdr_in),
    .i_valid  (i_tvalid & i_tlast & pay_in_rdy),
    .o_ready  (hdr_in_rdy),
    .o_data   (hdr_q),
    .o_valid  (hdr_valid),
    .i_ready  (hdr_fire)
  );

  ////////////////////
  // Output side

  assign hdr_fire = ~in_pay & hdr_valid & i_credit_ok;
  assign pay_fire = in_pay & pay_valid & i_credit_ok;

  always_comb begin
    hdr_out         = hdr_q;
    hdr_out.seqnum  = seq_q;
    hdr_out.src_sid = i_src_sid;
    hdr_out.dst_sid = i_dst_sid;
  end

  assign o_tvalid = hdr_fire | pay_fire;
  assign o_tdata  = in_pay ? pay_data : chdr_pkg::chdr_word_t'(hdr_out);
  assign o_tlast  = pay_fire & (left == '0);

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      in_pay <= 1'b0;
      seq_q  <= '0;
    end else begin
      if (hdr_fire) begin
        in_pay <= 1'b1;
      end else if (pay_fire && left == '0) begin
        in_pay <= 1'b0;
      end
      // Clear wins over the per-packet increment
      if (i_seq_clear) begin
        seq_q <= '0;
      end else if (hdr_fire) begin
        seq_q <= seq_q + 1'b1;
      end
    end
  end

  // Words left after the current one
  always_ff @(posedge i_ce_clk) begin
    if (hdr_fire) begin
      left <= CNT_W'(hdr_q.size / 16'(chdr_pkg::BYTES_PER_WORD) - 16'd2);
    end else if (pay_fire) begin
      left <= left - 1'b1;
    end
  end

endmodule

/* split_stream_ctrl.sv */
/*
 * Split stream control: settings registers, sequence clears and
 * per-branch output credit counters
 */
module split_stream_ctrl #(
  parameter int NUM_OUTPUTS = 2,
  parameter int CREDITS     = 16
) (
  input  logic                                      i_ce_clk,
  input  logic                                      i_rst,
  input  logic                                      i_set_stb,
  input  logic [split_cfg_pkg::SET_ADDR_W-1:0]      i_set_addr,
  input  logic [split_cfg_pkg::SET_DATA_W-1:0]      i_set_data,
  input  logic [NUM_OUTPUTS-1:0]                    i_credit,
  input  logic [NUM_OUTPUTS-1:0]                    i_sent,
  output logic [NUM_OUTPUTS-1:0]                    o_credit_ok,
  output logic [NUM_OUTPUTS*chdr_pkg::SID_W-1:0]    o_src_sid,
  output logic [NUM_OUTPUTS*chdr_pkg::SID_W-1:0]    o_dst_sid,
  output logic [NUM_OUTPUTS-1:0]                    o_seq_clear
);

  localparam int SID_W = chdr_pkg::SID_W;
  localparam int AW    = split_cfg_pkg::SET_ADDR_W;
  localparam int CW    = split_cfg_pkg::CREDIT_W;

  logic clear_wr;

  assign clear_wr = i_set_stb & (i_set_addr == split_cfg_pkg::REG_CLEAR_SEQ);

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      o_seq_clear <= '0;
    end else begin
      o_seq_clear <= clear_wr ? i_set_data[NUM_OUTPUTS-1:0] : '0;
    end
  end

  for (genvar k = 0; k < NUM_OUTPUTS; k++) begin : g_branch
    logic          src_wr;
    logic          dst_wr;
    logic [CW-1:0] credit_cnt;

    assign src_wr = i_set_stb & (i_set_addr == AW'(split_cfg_pkg::REG_SID_BASE + 2 * k));
    assign dst_wr = i_set_stb & (i_set_addr == AW'(split_cfg_pkg::REG_SID_BASE + 2 * k + 1));

    ////////////////////
    // Stream IDs

    always_ff @(posedge i_ce_clk) begin
      if (i_rst) begin
        o_src_sid[k*SID_W +: SID_W] <= '0;
        o_dst_sid[k*SID_W +: SID_W] <= '0;
      end else begin
        if (src_wr) begin
          o_src_sid[k*SID_W +: SID_W] <= i_set_data[SID_W-1:0];
        end
        if (dst_wr) begin
          o_dst_sid[k*SID_W +: SID_W] <= i_set_data[SID_W-1:0];
        end
      end
    end

    ////////////////////
    // Credits

    always_ff @(posedge i_ce_clk) begin
      if (i_rst) begin
        credit_cnt <= CW'(CREDITS);
      end else if (i_sent[k] && !i_credit[k]) begin
        credit_cnt <= credit_cnt - 1'b1;
      end else if (i_credit[k] && !i_sent[k]) begin
        credit_cnt <= credit_cnt + 1'b1;
      end
    end

    assign o_credit_ok[k] = (credit_cnt != '0);

    assert property (@(posedge i_ce_clk) disable iff (i_rst)
      credit_cnt <= CW'(CREDITS))
      else $error("branch %0d credit count above limit", k);

    // Framer must not send once the window is used up
    assert property (@(posedge i_ce_clk) disable iff (i_rst)
      i_sent[k] |-> (credit_cnt != '0))
      else $error("branch %0d sent without credit", k);
  end

endmodule

/* split_stream_block.sv */
/*
 * Split stream block: deframes CHDR input, copies the payload to every
 * branch and reframes each copy under credit flow control
 */
module split_stream_block #(
  parameter int NUM_OUTPUTS = 2,
  parameter int CREDITS     = 16,
  parameter int MTU_LOG2    = 6
) (
  input  logic                                 i_ce_clk,
  input  logic                                 i_rst,
  input  chdr_pkg::chdr_word_t                 i_tdata,
  input  logic                                 i_tlast,
  input  logic                                 i_tvalid,
  output logic                                 o_tready,
  input  logic                                 i_set_stb,
  input  logic [split_cfg_pkg::SET_ADDR_W-1:0] i_set_addr,
  input  logic [split_cfg_pkg::SET_DATA_W-1:0] i_set_data,
  input  logic [NUM_OUTPUTS-1:0]               i_credit,
  output logic [NUM_OUTPUTS*64-1:0]            o_out_tdata,
  output logic [NUM_OUTPUTS-1:0]               o_out_tlast,
  output logic [NUM_OUTPUTS-1:0]               o_out_tvalid
);

  localparam int WORD_W = $bits(chdr_pkg::chdr_word_t);
  localparam int HDR_W  = $bits(chdr_pkg::hdr_info_t);
  localparam int SID_W  = chdr_pkg::SID_W;

  chdr_pkg::chdr_word_t               dfr_tdata;
  chdr_pkg::hdr_info_t                dfr_hdr;
  logic                               dfr_tlast;
  logic                               dfr_tvalid;
  logic                               dfr_tready;
  logic [NUM_OUTPUTS*WORD_W-1:0]      spl_tdata;
  logic [NUM_OUTPUTS*HDR_W-1:0]       spl_hdr;
  logic [NUM_OUTPUTS-1:0]             spl_tlast;
  logic [NUM_OUTPUTS-1:0]             spl_tvalid;
  logic [NUM_OUTPUTS-1:0]             spl_tready;
  logic [NUM_OUTPUTS-1:0]             credit_ok;
  logic [NUM_OUTPUTS*SID_W-1:0]       src_sid;
  logic [NUM_OUTPUTS*SID_W-1:0]       dst_sid;
  logic [NUM_OUTPUTS-1:0]             seq_clear;

  split_stream_ctrl #(
    .NUM_OUTPUTS (NUM_OUTPUTS),
    .CREDITS     (CREDITS)
  ) u_ctrl (
    .i_ce_clk    (i_ce_clk),
    .i_rst       (i_rst),
    .i_set_stb   (i_set_stb),
    .i_set_addr  (i_set_addr),
    .i_set_data  (i_set_data),
    .i_credit    (i_credit),
    .i_sent      (o_out_tvalid),
    .o_credit_ok (credit_ok),
    .o_src_sid   (src_sid),
    .o_dst_sid   (dst_sid),
    .o_seq_clear (seq_clear)
  );

  chdr_deframer u_deframer (
    .i_ce_clk (i_ce_clk),
    .i_rst    (i_rst),
    .i_tdata  (i_tdata),
    .i_tlast  (i_tlast),
    .i_tvalid (i_tvalid),
    .o_tready (o_tready),
    .o_tdata  (dfr_tdata),
    .o_hdr    (dfr_hdr),
    .o_tlast  (dfr_tlast),
    .o_tvalid (dfr_tvalid),
    .i_tready (dfr_tready)
  );

  stream_splitter #(
    .NUM_OUTPUTS (NUM_OUTPUTS)
  ) u_splitter (
    .i_ce_clk (i_ce_clk),
    .i_rst    (i_rst),
    .i_tdata  (dfr_tdata),
    .i_hdr    (dfr_hdr),
    .i_tlast  (dfr_tlast),
    .i_tvalid (dfr_tvalid),
    .o_tready (dfr_tready),
    .o_tdata  (spl_tdata),
    .o_hdr    (spl_hdr),
    .o_tlast  (spl_tlast),
    .o_tvalid (spl_tvalid),
    .i_tready (spl_tready)
  );

  // One framer per output branch
  for (genvar k = 0; k < NUM_OUTPUTS; k++) begin : g_framer
    chdr_framer #(
      .MTU_LOG2 (MTU_LOG2)
    ) u_framer (
      .i_ce_clk    (i_ce_clk),
      .i_rst       (i_rst),
      .i_tdata     (spl_tdata[k*WORD_W +: WORD_W]),
      .i_hdr       (spl_hdr[k*HDR_W +: HDR_W]),
      .i_tlast     (spl_tlast[k]),
      .i_tvalid    (spl_tvalid[k]),
      .o_tready    (spl_tready[k]),
      .o_tdata     (o_out_tdata[k*WORD_W +: WORD_W]),
      .o_tlast     (o_out_tlast[k]),
      .o_tvalid    (o_out_tvalid[k]),
      .i_credit_ok (credit_ok[k]),
      .i_src_sid   (src_sid[k*SID_W +: SID_W]),
      .i_dst_sid   (dst_sid[k*SID_W +: SID_W]),
      .i_seq_clear (seq_clear[k])
    );
  end

endmodule

/* tb_split_stream_checker.sv */
/*
 * Split stream checker: models the expected packets per branch from the
 * DUT input and settings writes, and compares every output word
 */
module tb_split_stream_checker #(
  parameter int NUM_OUTPUTS = 2,
  parameter int CREDITS     = 16
) (
  input  logic                                 i_ce_clk,
  input  logic                                 i_rst,
  input  logic [63:0]                          i_tdata,
  input  logic                                 i_tlast,
  input  logic                                 i_tvalid,
  input  logic                                 i_tready,
  input  logic                                 i_set_stb,
  input  logic [split_cfg_pkg::SET_ADDR_W-1:0] i_set_addr,
  input  logic [split_cfg_pkg::SET_DATA_W-1:0] i_set_data,
  input  logic [NUM_OUTPUTS-1:0]               i_credit,
  input  logic [NUM_OUTPUTS*64-1:0]            i_out_tdata,
  input  logic [NUM_OUTPUTS-1:0]               i_out_tlast,
  input  logic [NUM_OUTPUTS-1:0]               i_out_tvalid,
  input  logic                                 i_report,
  output int                                   o_backlog,
  output int                                   o_errors
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int T_DUP         = 0;
  localparam int T_ADDR        = 1;
  localparam int T_FRAME       = 2;
  localparam int T_SEQ         = 3;
  localparam int T_CREDIT      = 4;
  localparam int NUM_TESTS     = 5;
  localparam int STARVE_BRANCH = 1;

  int          n_checks [NUM_TESTS];
  int          n_errs   [NUM_TESTS];
  logic [63:0] exp_words [NUM_OUTPUTS][$];
  int          exp_len   [NUM_OUTPUTS][$];
  logic [3:0]  exp_flags [NUM_OUTPUTS][$];
  logic [15:0] sid_src     [NUM_OUTPUTS];
  logic [15:0] sid_dst     [NUM_OUTPUTS];
  logic [11:0] exp_seq     [NUM_OUTPUTS];
  int          words_left  [NUM_OUTPUTS];
  int          outstanding [NUM_OUTPUTS];
  int          starved     [NUM_OUTPUTS];
  logic        in_payload;
  logic [3:0]  in_flags;
  int          in_len;

  function automatic string test_label(input int test);
    case (test)
      T_DUP:   return "duplication";
      T_ADDR:  return "addressing";
      T_FRAME: return "framing";
      T_SEQ:   return "sequence";
      default: return "credit";
    endcase
  endfunction

  task automatic check_value(input int test, input string what,
                             input logic [63:0] exp, input logic [63:0] act);
    n_checks[test]++;
    if (exp !== act) begin
      n_errs[test]++;
      $display("[ERROR] %s %s: expected 0x%0h actual 0x%0h",
               test_label(test), what, exp, act);
    end
  endtask

  task automatic report_failure(input int test, input string msg);
    n_checks[test]++;
    n_errs[test]++;
    $display("%s: %s", test_label(test), msg);
  endtask

  ////////////////////
  // Output side

  task automatic compare_outputs();
    logic [63:0]         word;
    chdr_pkg::hdr_info_t hdr;
    int                  len;
    logic [3:0]          flags;
    for (int k = 0; k < NUM_OUTPUTS; k++) begin
      if (i_out_tvalid[k]) begin
        word = i_out_tdata[k*64 +: 64];
        if (words_left[k] == 0) begin
          if (exp_len[k].size() == 0) begin
            report_failure(T_DUP, $sformatf("branch %0d sent a header with no packet due", k));
          end else begin
            hdr   = chdr_pkg::hdr_info_t'(word);
            len   = exp_len[k].pop_front();
            flags = exp_flags[k].pop_front();
            check_value(T_ADDR, $sformatf("branch %0d src_sid", k), 64'(sid_src[k]),
                        64'(hdr.src_sid));
            check_value(T_ADDR, $sformatf("branch %0d dst_sid", k), 64'(sid_dst[k]),
                        64'(hdr.dst_sid));
            check_value(T_FRAME, $sformatf("branch %0d size", k),
                        64'((len + 1) * chdr_pkg::BYTES_PER_WORD), 64'(hdr.size));
            check_value(T_FRAME, $sformatf("branch %0d flags", k), 64'(flags),
                        64'(hdr.flags));
            check_value(T_FRAME, $sformatf("branch %0d header tlast", k), 64'(0),
                        64'(i_out_tlast[k]));
            check_value(T_SEQ, $sformatf("branch %0d seqnum", k), 64'(exp_seq[k]),
                        64'(hdr.seqnum));
            exp_seq[k]    = exp_seq[k] + 12'd1;
            words_left[k] = len;
            o_backlog--;
          end
        end else begin
          if (exp_words[k].size() == 0) begin
            report_failure(T_DUP, $sformatf("branch %0d sent a payload word never input", k));
          end else begin
            check_value(T_DUP, $sformatf("branch %0d payload", k),
                        exp_words[k].pop_front(), word);
          end
          check_value(T_FRAME, $sformatf("branch %0d tlast", k),
                      64'(words_left[k] == 1), 64'(i_out_tlast[k]));
          words_left[k]--;
          o_backlog--;
        end
      end
    end
  endtask

  // Words sent and not yet returned against the CREDITS window
  task automatic track_credit();
    for (int k = 0; k < NUM_OUTPUTS; k++) begin
      if (outstanding[k] >= CREDITS) begin
        starved[k]++;
      end
      if (i_out_tvalid[k]) begin
        if (outstanding[k] >= CREDITS) begin
          report_failure(T_CREDIT, $sformatf("branch %0d sent a word with no credit left", k));
        end else begin
          n_checks[T_CREDIT]++;
        end
      end
      outstanding[k] += int'(i_out_tvalid[k]) - int'(i_credit[k]);
    end
  endtask

  ////////////////////
  // Input and settings

  task automatic record_input();
    chdr_pkg::hdr_info_t in_hdr;
    if (i_tvalid && i_tready) begin
      if (!in_payload) begin
        in_hdr     = chdr_pkg::hdr_info_t'(i_tdata);
        in_flags   = in_hdr.flags;
        in_len     = 0;
        in_payload = 1'b1;
      end else begin
        for (int k = 0; k < NUM_OUTPUTS; k++) begin
          exp_words[k].push_back(i_tdata);
        end
        in_len++;
        if (i_tlast) begin
          for (int k = 0; k < NUM_OUTPUTS; k++) begin
            exp_len[k].push_back(in_len);
            exp_flags[k].push_back(in_flags);
          end
          o_backlog += NUM_OUTPUTS * (in_len + 1);
          in_payload = 1'b0;
        end
      end
    end
  endtask

  task automatic apply_settings();
    if (i_set_stb) begin
      for (int k = 0; k < NUM_OUTPUTS; k++) begin
        if (int'(i_set_addr) == int'(split_cfg_pkg::REG_SID_BASE) + 2 * k) begin
          sid_src[k] = i_set_data[15:0];
        end
        if (int'(i_set_addr) == int'(split_cfg_pkg::REG_SID_BASE) + 2 * k + 1) begin
          sid_dst[k] = i_set_data[15:0];
        end
        if (i_set_addr == split_cfg_pkg::REG_CLEAR_SEQ && i_set_data[k]) begin
          exp_seq[k] = '0;
        end
      end
    end
  endtask

  task automatic print_summary();
    int total_checks;
    int total_errs;
    total_checks = 0;
    total_errs   = 0;
    if (starved[STARVE_BRANCH] == 0) begin
      report_failure(T_CREDIT, "branch 1 never ran out of credit");
    end
    for (int k = 0; k < NUM_OUTPUTS; k++) begin
      if (exp_words[k].size() != 0 || exp_len[k].size() != 0) begin
        report_failure(T_DUP, $sformatf("branch %0d left %0d payload words unsent", k,
                                        exp_words[k].size()));
      end
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      $display("%-12s %0d checks, %0d errors", test_label(t), n_checks[t], n_errs[t]);
      total_checks += n_checks[t];
      total_errs   += n_errs[t];
    end
    $display("checks: %0d, errors: %0d", total_checks, total_errs);
    o_errors = total_errs;
  endtask

  // Outputs are checked before this edge's settings take effect
  always @(posedge i_ce_clk) begin
    if (i_rst) begin
      for (int k = 0; k < NUM_OUTPUTS; k++) begin
        exp_words[k].delete();
        exp_len[k].delete();
        exp_flags[k].delete();
        sid_src[k]     = '0;
        sid_dst[k]     = '0;
        exp_seq[k]     = '0;
        words_left[k]  = 0;
        outstanding[k] = 0;
        starved[k]     = 0;
      end
      for (int t = 0; t < NUM_TESTS; t++) begin
        n_checks[t] = 0;
        n_errs[t]   = 0;
      end
      in_payload = 1'b0;
      o_backlog  = 0;
      o_errors   = 0;
    end else begin
      compare_outputs();
      track_credit();
      record_input();
      apply_settings();
      if (i_report) begin
        print_summary();
      end
    end
  end

endmodule

/* tb_split_stream.sv */
/*
 * Split stream testbench: random CHDR packets, settings writes and
 * randomly delayed credit return around the split stream block
 */
module tb_split_stream;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          NUM_OUTPUTS  = 2;
  localparam int          CREDITS      = 16;
  localparam int          MTU_LOG2     = 6;
  localparam int          ADDR_W       = split_cfg_pkg::SET_ADDR_W;
  localparam int          HOLD_BRANCH  = 1;
  localparam int          CLEAR_BRANCH = 1;
  localparam int          WAIT_LIMIT   = 20000;
  localparam logic [31:0] SEED         = 32'h3c4c_90d6;

  logic                                 clk = 1'b0;
  logic                                 rst;
  logic [63:0]                          tdata;
  logic                                 tlast;
  logic                                 tvalid;
  logic                                 tready;
  logic                                 set_stb;
  logic [ADDR_W-1:0]                    set_addr;
  logic [split_cfg_pkg::SET_DATA_W-1:0] set_data;
  logic [NUM_OUTPUTS-1:0]               credit = '0;
  logic [NUM_OUTPUTS*64-1:0]            out_tdata;
  logic [NUM_OUTPUTS-1:0]               out_tlast;
  logic [NUM_OUTPUTS-1:0]               out_tvalid;
  logic                                 report;
  int                                   chk_backlog;
  int                                   chk_errors;
  logic [NUM_OUTPUTS-1:0]               hold;
  logic [NUM_OUTPUTS-1:0]               held;
  int                                   pending [NUM_OUTPUTS] = '{default: 0};
  logic [31:0]                          stim_rng;
  logic [31:0]                          credit_rng = ~SEED;
  logic                                 timed_out;

  always #4 clk = ~clk;

  split_stream_block #(
    .NUM_OUTPUTS (NUM_OUTPUTS),
    .CREDITS     (CREDITS),
    .MTU_LOG2    (MTU_LOG2)
  ) dut (
    .i_ce_clk     (clk),
    .i_rst        (rst),
    .i_tdata      (tdata),
    .i_tlast      (tlast),
    .i_tvalid     (tvalid),
    .o_tready     (tready),
    .i_set_stb    (set_stb),
    .i_set_addr   (set_addr),
    .i_set_data   (set_data),
    .i_credit     (credit),
    .o_out_tdata  (out_tdata),
    .o_out_tlast  (out_tlast),
    .o_out_tvalid (out_tvalid)
  );

  tb_split_stream_checker #(
    .NUM_OUTPUTS (NUM_OUTPUTS),
    .CREDITS     (CREDITS)
  ) checker_inst (
    .i_ce_clk     (clk),
    .i_rst        (rst),
    .i_tdata      (tdata),
    .i_tlast      (tlast),
    .i_tvalid     (tvalid),
    .i_tready     (tready),
    .i_set_stb    (set_stb),
    .i_set_addr   (set_addr),
    .i_set_data   (set_data),
    .i_credit     (credit),
    .i_out_tdata  (out_tdata),
    .i_out_tlast  (out_tlast),
    .i_out_tvalid (out_tvalid),
    .i_report     (report),
    .o_backlog    (chk_backlog),
    .o_errors     (chk_errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  ////////////////////
  // Credit return

  // Each sent word comes back as one credit pulse after a random delay
  always @(posedge clk) begin
    for (int k = 0; k < NUM_OUTPUTS; k++) begin
      if (out_tvalid[k]) begin
        pending[k]++;
      end
    end
    held = hold;
    #1;
    for (int k = 0; k < NUM_OUTPUTS; k++) begin
      credit_rng = xorshift32(credit_rng);
      if (!rst && !held[k] && pending[k] > 0 && credit_rng[1:0] != 2'b00) begin
        credit[k] = 1'b1;
        pending[k]--;
      end else begin
        credit[k] = 1'b0;
      end
    end
  end

  ////////////////////
  // Stimulus

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drive_word(input logic [63:0] data, input logic last);
    int   waited;
    logic fired;
    if (timed_out) begin
      return;
    end
    tdata  = data;
    tlast  = last;
    tvalid = 1'b1;
    waited = 0;
    fired  = 1'b0;
    while (!fired && !timed_out) begin
      @(posedge clk);
      if (tready) begin
        fired = 1'b1;
      end else if (waited == WAIT_LIMIT) begin
        timed_out = 1'b1;
        $display("timeout: input word was never accepted by the DUT");
      end else begin
        waited++;
      end
    end
    #1;
    tvalid = 1'b0;
    tlast  = 1'b0;
  endtask

  task automatic send_packet(input int min_len, input int span);
    int          len;
    logic [31:0] r;
    logic [31:0] r2;
    len = min_len + int'(next_rand() % 32'(span));
    r   = next_rand();
    r2  = next_rand();
    drive_word({r[31:28], r[27:16], 16'((len + 1) * chdr_pkg::BYTES_PER_WORD), r2}, 1'b0);
    for (int i = 0; i < len; i++) begin
      drive_word({next_rand(), next_rand()}, i == len - 1);
    end
    idle_cycles(int'(next_rand() % 32'd4));
  endtask

  task automatic send_burst(input int count, input int min_len, input int span);
    for (int p = 0; p < count; p++) begin
      send_packet(min_len, span);
    end
  endtask

  task automatic write_setting(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
    set_stb  = 1'b1;
    set_addr = addr;
    set_data = data;
    @(posedge clk);
    #1;
    set_stb = 1'b0;
  endtask

  task automatic write_sids();
    logic [31:0] r;
    for (int k = 0; k < NUM_OUTPUTS; k++) begin
      r = next_rand();
      write_setting(ADDR_W'(int'(split_cfg_pkg::REG_SID_BASE) + 2 * k), {16'h0, r[15:0]});
      write_setting(ADDR_W'(int'(split_cfg_pkg::REG_SID_BASE) + 2 * k + 1), {16'h0, r[31:16]});
    end
  endtask

  // Backlog is read one step after the edge when the checker has updated it
  task automatic wait_drained();
    int waited;
    waited = 0;
    while (!timed_out && chk_backlog != 0) begin
      idle_cycles(1);
      if (waited == WAIT_LIMIT) begin
        timed_out = 1'b1;
        $display("timeout: %0d expected output words never arrived", chk_backlog);
      end else begin
        waited++;
      end
    end
    idle_cycles(4);
  endtask

  initial begin
    rst       = 1'b1;
    tdata     = '0;
    tlast     = 1'b0;
    tvalid    = 1'b0;
    set_stb   = 1'b0;
    set_addr  = '0;
    set_data  = '0;
    report    = 1'b0;
    hold      = '0;
    timed_out = 1'b0;
    stim_rng  = SEED;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    write_sids();
    send_burst(20, 1, 40);
    wait_drained();

    // SID rewrite between packets
    write_sids();
    idle_cycles(4);
    send_burst(10, 1, 40);
    wait_drained();

    write_setting(split_cfg_pkg::REG_CLEAR_SEQ, 32'd1 << CLEAR_BRANCH);
    idle_cycles(4);
    send_burst(8, 1, 40);
    wait_drained();

    // Starve one branch and then let its credits flow again
    hold[HOLD_BRANCH] = 1'b1;
    send_burst(2, 10, 10);
    idle_cycles(200);
    hold[HOLD_BRANCH] = 1'b0;
    wait_drained();
    send_burst(10, 1, 40);
    wait_drained();

    report = 1'b1;
    @(posedge clk);
    #1;
    report = 1'b0;
    if (chk_errors == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* sim.f */
chdr_pkg.sv
split_cfg_pkg.sv
stream_fifo.sv
chdr_deframer.sv
stream_splitter.sv
chdr_framer.sv
split_stream_ctrl.sv
split_stream_block.sv
tb_split_stream_checker.sv
tb_split_stream.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --top-module tb_split_stream -f sim.f \
  && ./obj_dir/Vtb_split_stream | tee /dev/stderr | grep -qx "all tests passed" \
  || { echo "simulation failed"; exit 1; }
